//--- logic/cart_pkg.sv
/*
 shared types, note table and constants of the MSX I/O cartridge.
 modules pull these in by wildcard import in their header
*/
package cart_pkg;

	// --------------------
	// bus side
	// --------------------

	// one decoded I/O access, read and write are single-cycle pulses
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        read;
		logic        write;
	} bus_req_t;

	// reply of an I/O device to the current request
	typedef struct packed {
		logic       hit;
		logic [7:0] rdata;
	} io_rsp_t;

	// port 01h, compared with the low address byte only
	localparam logic [7:0] GPIO_PORT = 8'h01;

	// dip switch bit that lets the cartridge drive the data bus
	localparam int TD_ENABLE_SW = 6;
	localparam int LED_WIDTH = 6;
	localparam int RESET_SYNC_LEN = 6;

	// --------------------
	// tone demo
	// --------------------

	// divisor is half a period in ticks, minus one
	typedef struct packed {
		logic [15:0] divisor;
		logic [7:0]  level;
	} note_t;

	localparam int NOTE_COUNT = 8;

	// C4 up to C5, loudness falls with each step
	localparam note_t NOTE_TABLE [NOTE_COUNT] = '{
		'{divisor: 16'd1911, level: 8'hFF},
		'{divisor: 16'd1702, level: 8'hCC},
		'{divisor: 16'd1516, level: 8'hAA},
		'{divisor: 16'd1431, level: 8'h88},
		'{divisor: 16'd1275, level: 8'h66},
		'{divisor: 16'd1136, level: 8'h44},
		'{divisor: 16'd1012, level: 8'h22},
		'{divisor: 16'd955,  level: 8'd11}
	};

	// clocks per tick and ticks per note
	localparam int TICK_DIV_DEFAULT = 64;
	localparam int NOTE_TICKS_DEFAULT = 100000;

endpackage

//--- logic/reset_sync.sv
/*
 turns the raw cartridge reset into the internal synchronous reset.
 release waits until the input has been high for the whole chain
*/
`timescale 1ns/1ps

module reset_sync import cart_pkg::*; (
	input  logic clk,
	input  logic n_treset,
	output logic w_n_reset
);

	// chain powers up low so the design starts out in reset
	logic [RESET_SYNC_LEN-1:0] ff_chain = '0;
	logic                      ff_release = 1'b0;

	always_ff @(posedge clk) begin
		ff_chain <= {ff_chain[RESET_SYNC_LEN-2:0], n_treset};
		// any low sample in the chain holds reset for another pass
		ff_release <= &ff_chain;
	end

	assign w_n_reset = ff_release;

endmodule

//--- logic/msx_bus_decode.sv
/*
 MSX bus front end. samples the asynchronous I/O strobes, address and data
 through two flops and emits one request pulse at the start of each access.
 rd_active stays high for as long as the I/O read lasts
*/
`timescale 1ns/1ps

module msx_bus_decode import cart_pkg::*; (
	input  logic        clk,
	input  logic        w_n_reset,
	input  logic        n_tiorq,
	input  logic        n_trd,
	input  logic        n_twr,
	input  logic [15:0] ta,
	input  logic [7:0]  td_in,
	output bus_req_t    req,
	output logic        rd_active
);

	// strobes packed as {iorq, rd, wr}, all active low
	logic [2:0]  ff_strb_s1;
	logic [2:0]  ff_strb_s2;
	logic [15:0] ff_addr_s1;
	logic [15:0] ff_addr_s2;
	logic [7:0]  ff_data_s1;
	logic [7:0]  ff_data_s2;

	// request register
	logic [15:0] ff_addr;
	logic [7:0]  ff_wdata;
	logic        ff_read;
	logic        ff_write;

	// access levels seen one cycle ago
	logic        ff_rd_level;
	logic        ff_wr_level;

	logic        w_rd_now;
	logic        w_wr_now;

	// --------------------
	// input sampling
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			// idle bus is all strobes high
			ff_strb_s1 <= 3'b111;
			ff_strb_s2 <= 3'b111;
		end else begin
			ff_strb_s1 <= {n_tiorq, n_trd, n_twr};
			ff_strb_s2 <= ff_strb_s1;
		end
	end

	always_ff @(posedge clk) begin
		ff_addr_s1 <= ta;
		ff_addr_s2 <= ff_addr_s1;
		ff_data_s1 <= td_in;
		ff_data_s2 <= ff_data_s1;
	end

	// io read or write in progress on the sampled strobes
	assign w_rd_now = !ff_strb_s2[2] && !ff_strb_s2[1];
	assign w_wr_now = !ff_strb_s2[2] && !ff_strb_s2[0];

	// --------------------
	// pulse generation
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_rd_level <= 1'b0;
			ff_wr_level <= 1'b0;
			ff_read     <= 1'b0;
			ff_write    <= 1'b0;
		end else begin
			ff_rd_level <= w_rd_now;
			ff_wr_level <= w_wr_now;
			// first cycle of the access only
			ff_read     <= w_rd_now && !ff_rd_level;
			ff_write    <= w_wr_now && !ff_wr_level;
		end
	end

	// address and data ride along with the pulse
	always_ff @(posedge clk) begin
		ff_addr  <= ff_addr_s2;
		ff_wdata <= ff_data_s2;
	end

	assign req = '{addr: ff_addr, wdata: ff_wdata, read: ff_read, write: ff_write};
	assign rd_active = ff_rd_level;

	// a Z80 never reads and writes in the same bus cycle
	assert property (@(posedge clk) disable iff (!w_n_reset)
		!(req.read && req.write));

endmodule

//--- logic/io_port.sv
/*
 general-purpose I/O port at 01h. writes load the output register,
 reads return the DIP switches. decode is combinational on the request
*/
`timescale 1ns/1ps

module io_port import cart_pkg::*; (
	input  logic       clk,
	input  logic       w_n_reset,
	input  bus_req_t   req,
	input  logic [6:0] dip_sw,
	output io_rsp_t    rsp,
	output logic [7:0] gpo
);

	logic       w_match;
	logic [7:0] ff_gpo;

	// only the low address byte decodes on MSX I/O
	assign w_match = (req.addr[7:0] == GPIO_PORT);

	// reply in the same cycle as the pulse
	assign rsp = '{
		hit:   w_match && (req.read || req.write),
		rdata: {1'b0, dip_sw}
	};

	// output register
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_gpo <= 8'h00;
		end else if (w_match && req.write) begin
			ff_gpo <= req.wdata;
		end
	end

	assign gpo = ff_gpo;

	// one load per bus write, the front end must not stretch the pulse
	assert property (@(posedge clk) disable iff (!w_n_reset)
		req.write |=> !req.write);

endmodule

//--- logic/tone_sequencer.sv
/*
 tone demo. a tick every tick_div clocks drives a note timer and a tone
 divider. the note table is stepped in a loop, sample toggles between 0
 and the level of the current note at each divider expiry
*/
`timescale 1ns/1ps

module tone_sequencer import cart_pkg::*; #(
	parameter int tick_div   = TICK_DIV_DEFAULT,
	parameter int note_ticks = NOTE_TICKS_DEFAULT
) (
	input  logic       clk,
	input  logic       w_n_reset,
	output logic       tick,
	output logic [7:0] sample
);

	localparam int TICK_W = (tick_div > 1) ? $clog2(tick_div) : 1;
	localparam int NOTE_W = (note_ticks > 1) ? $clog2(note_ticks) : 1;
	localparam int IDX_W = $clog2(NOTE_COUNT);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(tick_div - 1);
	localparam logic [NOTE_W-1:0] NOTE_LAST = NOTE_W'(note_ticks - 1);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(NOTE_COUNT - 1);

	logic [TICK_W-1:0] ff_tick_cnt;
	logic              ff_tick;
	logic [15:0]       ff_div_cnt;
	logic [NOTE_W-1:0] ff_note_cnt;
	logic [IDX_W-1:0]  ff_idx;
	note_t             ff_note;
	logic [7:0]        ff_sample;
	logic              w_flip;
	logic              w_note_end;

	// --------------------
	// tick
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_tick_cnt <= TICK_LAST;
			ff_tick     <= 1'b0;
		end else if (ff_tick_cnt == '0) begin
			ff_tick_cnt <= TICK_LAST;
			ff_tick     <= 1'b1;
		end else begin
			ff_tick_cnt <= ff_tick_cnt - 1'b1;
			ff_tick     <= 1'b0;
		end
	end

	assign w_flip = (ff_div_cnt == 16'd0);
	assign w_note_end = (ff_note_cnt == '0);

	// --------------------
	// tone divider and square wave
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_div_cnt <= 16'd0;
			ff_sample  <= 8'h00;
		end else if (ff_tick) begin
			if (w_flip) begin
				ff_div_cnt <= ff_note.divisor;
				// half period over, swap between silence and level
				ff_sample  <= (ff_sample != 8'h00) ? 8'h00 : ff_note.level;
			end else begin
				ff_div_cnt <= ff_div_cnt - 16'd1;
			end
		end
	end

	// --------------------
	// note stepping
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_note_cnt <= NOTE_LAST;
		end else if (ff_tick) begin
			ff_note_cnt <= w_note_end ? NOTE_LAST : ff_note_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			// full level, fastest toggle until the first note is loaded
			ff_note <= '{divisor: 16'd0, level: 8'hFF};
			ff_idx  <= '0;
		end else if (ff_tick && w_note_end) begin
			ff_note <= NOTE_TABLE[ff_idx];
			ff_idx  <= (ff_idx == IDX_LAST) ? '0 : ff_idx + 1'b1;
		end
	end

	assign tick = ff_tick;
	assign sample = ff_sample;

endmodule

//--- logic/pwm_dac.sv
/*
 8-bit PWM DAC for the sound pin. one frame is 256 ticks, the sample is
 taken at the frame start and held for the whole frame
*/
`timescale 1ns/1ps

module pwm_dac (
	input  logic       clk,
	input  logic       w_n_reset,
	input  logic       tick,
	input  logic [7:0] sample,
	output logic       tsnd
);

	logic [7:0] ff_phase;
	logic [7:0] ff_level;

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_phase <= 8'h00;
			ff_level <= 8'h00;
		end else if (tick) begin
			ff_phase <= ff_phase + 8'd1;
			// phase wraps to 0 here, new frame
			if (ff_phase == 8'hFF) begin
				ff_level <= sample;
			end
		end
	end

	// high for level ticks out of 256
	assign tsnd = (ff_phase < ff_level);

endmodule

//--- logic/bus_read_return.sv
/*
 read return path. latches the reply of a read that hits and drives the
 data bus until the read strobe goes away. tdir trails td_oe by a cycle
*/
`timescale 1ns/1ps

module bus_read_return import cart_pkg::*; (
	input  logic       clk,
	input  logic       w_n_reset,
	input  bus_req_t   req,
	input  io_rsp_t    rsp,
	input  logic       rd_active,
	input  logic       drive_en,
	output logic [7:0] td_out,
	output logic       td_oe,
	output logic       tdir
);

	logic [7:0] ff_rdata;
	logic       ff_oe;
	logic       ff_dir;
	logic       w_rd_hit;

	assign w_rd_hit = req.read && rsp.hit;

	// read data held for the rest of the access
	always_ff @(posedge clk) begin
		if (w_rd_hit) begin
			ff_rdata <= rsp.rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_oe  <= 1'b0;
			ff_dir <= 1'b0;
		end else begin
			// release the bus once the strobe is gone or the switch is off
			if (!rd_active || !drive_en) begin
				ff_oe <= 1'b0;
			end else if (w_rd_hit) begin
				ff_oe <= 1'b1;
			end
			ff_dir <= ff_oe;
		end
	end

	assign td_out = ff_rdata;
	assign td_oe = ff_oe;
	assign tdir = ff_dir;

	// rd_active is up together with the read pulse or td_oe never rises
	assert property (@(posedge clk) disable iff (!w_n_reset)
		req.read |-> rd_active);

endmodule

//--- logic/tangcart_top.sv
/*
 top level of the MSX I/O cartridge. bus front end, port 01h with LEDs
 and switches, read return, and the tone demo on the sound pin
*/
`timescale 1ns/1ps

module tangcart_top import cart_pkg::*; #(
	parameter int tick_div   = TICK_DIV_DEFAULT,
	parameter int note_ticks = NOTE_TICKS_DEFAULT
) (
	input  logic                 clk,
	input  logic                 n_treset,
	input  logic                 n_tiorq,
	input  logic                 n_trd,
	input  logic                 n_twr,
	input  logic [15:0]          ta,
	input  logic [7:0]           td_in,
	input  logic [6:0]           dip_sw,
	output logic [7:0]           td_out,
	output logic                 td_oe,
	output logic                 tdir,
	output logic                 tsnd,
	output logic [LED_WIDTH-1:0] n_led
);

	logic       w_n_reset;
	bus_req_t   w_req;
	io_rsp_t    w_rsp;
	logic       w_rd_active;
	logic [7:0] w_gpo;
	logic       w_tick;
	logic [7:0] w_sample;

	reset_sync reset_sync_i (
		.clk       (clk),
		.n_treset  (n_treset),
		.w_n_reset (w_n_reset)
	);

	// --------------------
	// I/O bus
	// --------------------
	msx_bus_decode msx_bus_decode_i (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.n_tiorq   (n_tiorq),
		.n_trd     (n_trd),
		.n_twr     (n_twr),
		.ta        (ta),
		.td_in     (td_in),
		.req       (w_req),
		.rd_active (w_rd_active)
	);

	io_port io_port_i (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.req       (w_req),
		.dip_sw    (dip_sw),
		.rsp       (w_rsp),
		.gpo       (w_gpo)
	);

	// data bus drive only with the enable switch on
	bus_read_return bus_read_return_i (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.req       (w_req),
		.rsp       (w_rsp),
		.rd_active (w_rd_active),
		.drive_en  (dip_sw[TD_ENABLE_SW]),
		.td_out    (td_out),
		.td_oe     (td_oe),
		.tdir      (tdir)
	);

	// low bits of the port drive the LEDs
	assign n_led = w_gpo[LED_WIDTH-1:0];

	// --------------------
	// sound
	// --------------------
	tone_sequencer #(
		.tick_div   (tick_div),
		.note_ticks (note_ticks)
	) tone_sequencer_i (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.tick      (w_tick),
		.sample    (w_sample)
	);

	pwm_dac pwm_dac_i (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.tick      (w_tick),
		.sample    (w_sample),
		.tsnd      (tsnd)
	);

endmodule

//--- bench/tangcart_tb.sv
/*
 testbench of the MSX I/O cartridge. runs a table of I/O bus operations
 against port 01h, then watches the sound pin for whole PWM frames
*/
`timescale 1ns/1ps

module tangcart_tb import cart_pkg::*; ();

	localparam int NOTE_TICKS_TB = 2000;
	// eight notes plus margin counted in clocks
	// one tick is one clock here
	localparam int TIMEOUT_CYCLES = NOTE_COUNT * NOTE_TICKS_TB + 2000;
	localparam int SOUND_CYCLES = 60 * 256;
	localparam int STROBE_CYCLES = 8;
	localparam int IDLE_CYCLES = 8;
	localparam int RESET_CYCLES = 8;
	localparam int RELEASE_CYCLES = 12;
	localparam int NUM_OPS = 14;
	localparam logic [1:0] KIND_WR = 2'd0;
	localparam logic [1:0] KIND_RD = 2'd1;
	localparam logic [1:0] KIND_LED = 2'd2;

	// one table row
	// drive marks a read that must raise td_oe
	typedef struct packed {
		logic [1:0]  kind;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [6:0]  sw;
		logic        drive;
		logic [7:0]  exp_val;
	} op_t;

	logic                 clk;
	logic                 n_treset;
	logic                 n_tiorq;
	logic                 n_trd;
	logic                 n_twr;
	logic [15:0]          ta;
	logic [7:0]           td_in;
	logic [6:0]           dip_sw;
	logic [7:0]           td_out;
	logic                 td_oe;
	logic                 tdir;
	logic                 tsnd;
	logic [LED_WIDTH-1:0] n_led;

	op_t        ops [NUM_OPS];
	string      op_names [NUM_OPS];
	int         op_count = 0;
	logic [7:0] gpo_model = 8'h00;
	int         cycle_count = 0;
	int         level_ptr = 0;
	int         levels_seen = 0;
	logic       sound_run = 1'b0;
	logic       sound_done = 1'b0;

	tangcart_top #(
		.tick_div   (1),
		.note_ticks (NOTE_TICKS_TB)
	) tangcart_top_i (
		.clk      (clk),
		.n_treset (n_treset),
		.n_tiorq  (n_tiorq),
		.n_trd    (n_trd),
		.n_twr    (n_twr),
		.ta       (ta),
		.td_in    (td_in),
		.dip_sw   (dip_sw),
		.td_out   (td_out),
		.td_oe    (td_oe),
		.tdir     (tdir),
		.tsnd     (tsnd),
		.n_led    (n_led)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		assert (cycle_count < TIMEOUT_CYCLES) else begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$fatal(1, "run stopped on timeout");
		end
	end

	task automatic expect_equal(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("FAILED %s expected %0h actual %0h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "run stopped at the first error");
		end
	endtask

	// --------------------
	// stimulus table
	// --------------------
	task automatic add_op(input string name, input op_t op);
		ops[op_count] = op;
		op_names[op_count] = name;
		op_count++;
	endtask

	// random write data and switches
	// a hit on port 01h updates the LED model
	task automatic add_write(input string name, input logic [15:0] addr);
		op_t op;
		op = '0;
		op.kind = KIND_WR;
		op.addr = addr;
		op.data = 8'($urandom());
		op.sw = 7'($urandom());
		if (addr[7:0] == GPIO_PORT) begin
			gpo_model = op.data;
		end
		add_op(name, op);
	endtask

	// switches come back zero-extended
	// drive only at port 01h with switch 6 set
	task automatic add_read(input string name, input logic [15:0] addr, input logic sw6);
		op_t op;
		op = '0;
		op.kind = KIND_RD;
		op.addr = addr;
		op.sw = 7'($urandom());
		op.sw[TD_ENABLE_SW] = sw6;
		op.drive = (addr[7:0] == GPIO_PORT) && sw6;
		op.exp_val = {1'b0, op.sw};
		add_op(name, op);
	endtask

	task automatic add_led_check(input string name);
		op_t op;
		op = '0;
		op.kind = KIND_LED;
		op.exp_val = {2'b00, gpo_model[LED_WIDTH-1:0]};
		add_op(name, op);
	endtask

	// --------------------
	// bus operation
	// --------------------
	task automatic apply_op(input string name, input op_t op);
		logic oe_seen;
		logic dir_seen;
		int   i;
		@(negedge clk);
		ta = op.addr;
		td_in = op.data;
		dip_sw = op.sw;
		if (op.kind == KIND_LED) begin
			expect_equal(name, int'(op.exp_val), int'(n_led));
		end else begin
			oe_seen = 1'b0;
			dir_seen = 1'b0;
			n_tiorq = 1'b0;
			n_twr = (op.kind == KIND_WR) ? 1'b0 : 1'b1;
			n_trd = (op.kind == KIND_RD) ? 1'b0 : 1'b1;
			for (i = 0; i < STROBE_CYCLES + IDLE_CYCLES; i++) begin
				@(negedge clk);
				// tdir only after td_oe has been seen
				if (tdir) begin
					dir_seen = 1'b1;
					expect_equal({name, "_tdir_after_oe"}, 1, int'(oe_seen));
				end
				if (td_oe) begin
					oe_seen = 1'b1;
					expect_equal({name, "_td_out"}, int'(op.exp_val), int'(td_out));
				end
				// strobes released after STROBE_CYCLES
				if (i == STROBE_CYCLES - 1) begin
					n_tiorq = 1'b1;
					n_trd = 1'b1;
					n_twr = 1'b1;
				end
			end
			expect_equal({name, "_td_oe_seen"}, int'(op.drive), int'(oe_seen));
			expect_equal({name, "_tdir_seen"}, int'(op.drive), int'(dir_seen));
			expect_equal({name, "_td_oe_end"}, 0, int'(td_oe));
			expect_equal({name, "_tdir_end"}, 0, int'(tdir));
		end
	endtask

	// --------------------
	// sound frames
	// --------------------
	function automatic int find_level(input int len, input int from);
		int j;
		find_level = -1;
		// lowest matching index at or after from
		for (j = NOTE_COUNT - 1; j >= from; j--) begin
			if (int'(NOTE_TABLE[j].level) == len) begin
				find_level = j;
			end
		end
	endfunction

	// one high run is one frame at the latched level
	task automatic check_frame(input int len);
		int j;
		if (levels_seen == 0) begin
			expect_equal("sound_first_level", int'(NOTE_TABLE[0].level), len);
			levels_seen = 1;
		end
		j = find_level(len, level_ptr);
		if (j < 0) begin
			expect_equal("sound_level_order", int'(NOTE_TABLE[level_ptr].level), len);
		end else if (j != level_ptr) begin
			level_ptr = j;
			levels_seen++;
		end
	endtask

	initial begin : sound_monitor
		int  cyc;
		int  high_len;
		int  low_len;
		int  prev_high;
		bit  seen_high;
		high_len = 0;
		low_len = 0;
		prev_high = 0;
		seen_high = 1'b0;
		wait (sound_run);
		for (cyc = 0; cyc < SOUND_CYCLES; cyc++) begin
			@(negedge clk);
			if (tsnd) begin
				// high plus low runs fill whole 256-cycle frames
				if (low_len > 0 && seen_high) begin
					expect_equal("sound_frame_length", 0, (prev_high + low_len) % 256);
				end
				low_len = 0;
				high_len++;
			end else begin
				if (high_len > 0) begin
					check_frame(high_len);
					prev_high = high_len;
					seen_high = 1'b1;
				end
				high_len = 0;
				low_len++;
			end
		end
		sound_done = 1'b1;
	end

	// --------------------
	// main sequence
	// --------------------
	initial begin : main_sequence
		int k;
		void'($urandom(32'h6d457f10));
		n_treset = 1'b0;
		n_tiorq = 1'b1;
		n_trd = 1'b1;
		n_twr = 1'b1;
		ta = 16'h0000;
		td_in = 8'h00;
		dip_sw = 7'h00;

		add_write("wr_port01", 16'h0001);
		add_led_check("led_port01");
		add_write("wr_port02", 16'h0002);
		add_led_check("led_after_port02");
		add_write("wr_port01_hi", 16'hA501);
		add_led_check("led_port01_hi");
		add_write("wr_port41", 16'h0041);
		add_led_check("led_after_port41");
		add_read("rd_port01_sw6", 16'h0001, 1'b1);
		add_read("rd_port11_sw6", 16'h0011, 1'b1);
		add_read("rd_port01_no_sw6", 16'h0001, 1'b0);
		add_read("rd_port01_hi_sw6", 16'h7F01, 1'b1);
		add_write("wr_port01_last", 16'h0001);
		add_led_check("led_port01_last");

		repeat (RESET_CYCLES) @(negedge clk);
		n_treset = 1'b1;
		// sync chain releases after a fixed number of cycles
		repeat (RELEASE_CYCLES) @(negedge clk);
		expect_equal("reset_td_oe", 0, int'(td_oe));
		expect_equal("reset_tdir", 0, int'(tdir));
		expect_equal("reset_tsnd", 0, int'(tsnd));
		expect_equal("reset_n_led", 0, int'(n_led));
		sound_run = 1'b1;

		for (k = 0; k < op_count; k++) begin
			apply_op(op_names[k], ops[k]);
		end

		wait (sound_done);
		assert (levels_seen >= 4) else begin
			$display("sound check saw only %0d different note levels", levels_seen);
			$display("Test FAILED");
			$fatal(1, "run stopped at the first error");
		end
		$display("Test OK");
		$finish;
	end

endmodule

//--- tangcart.f
logic/cart_pkg.sv
logic/reset_sync.sv
logic/msx_bus_decode.sv
logic/io_port.sv
logic/tone_sequencer.sv
logic/pwm_dac.sv
logic/bus_read_return.sv
logic/tangcart_top.sv
bench/tangcart_tb.sv

//--- Makefile
# Verilator build and run of the cartridge testbench

VERILATOR ?= verilator
TOP       ?= tangcart_tb
FILELIST  ?= tangcart.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
